// File: rtl/mem_pkg.sv
package mem_pkg;

	localparam int OFFSET_W = 3;   // Byte offset bits within a line
	localparam int WOFF_W = 2;     // Word offset bits, four words per line

	typedef logic [15:0] addr_t;   // Byte address
	typedef logic [15:0] word_t;
	typedef logic [15:0] tag_t;    // Only bits above the index are meaningful
	typedef logic [1:0] way_sel_t; // One bit per way

	typedef struct packed {
		logic rd;
		logic wr;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic done;
		logic stall;
		logic hit;
		logic err;
		word_t rdata;
	} cpu_rsp_t;

	// Memory side addresses are word addresses
	typedef struct packed {
		logic wr;
		addr_t addr;
		word_t data;
	} mem_req_t;

	typedef struct packed {
		logic rvalid;
		word_t rdata;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		ALLOC,
		WB_READ,
		FILL_REQ,
		FILL_WAIT,
		FINISH
	} ctrl_state_t;

endpackage

// File: rtl/cache_ways.sv
`timescale 1ns/1ps

module cache_ways #(
	parameter int IDX_W = 5
) (
	input  logic clk,
	input  logic rst_n,
	input  mem_pkg::way_sel_t way_en,
	input  logic comp,
	input  logic write,
	input  logic fill_src,
	input  logic [IDX_W-1:0] idx,
	input  logic [mem_pkg::WOFF_W-1:0] offset,
	input  mem_pkg::tag_t tag,
	input  mem_pkg::word_t wdata,
	input  mem_pkg::word_t fill_data,
	output mem_pkg::way_sel_t valid,
	output mem_pkg::way_sel_t dirty,
	output mem_pkg::way_sel_t hit,
	output mem_pkg::word_t rdata,
	output mem_pkg::tag_t stored_tag
);

	localparam int SETS = 2 ** IDX_W;
	localparam int WORDS = 2 ** mem_pkg::WOFF_W;

	mem_pkg::tag_t tag_arr [2][SETS];
	mem_pkg::word_t data_arr [2][SETS][WORDS];
	logic [1:0][SETS-1:0] valid_q;
	logic [1:0][SETS-1:0] dirty_q;
	mem_pkg::way_sel_t match;
	mem_pkg::way_sel_t cmp_we;
	mem_pkg::way_sel_t fill_we;
	mem_pkg::word_t fill_word;
	logic sel1;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = (tag_arr[w][idx] == tag);
			valid[w] = valid_q[w][idx];
			dirty[w] = dirty_q[w][idx];
		end
	end

	assign hit = way_en & match;
	assign cmp_we = {2{write & comp}} & hit & valid;   // Write hit only
	assign fill_we = {2{write & ~comp}} & way_en;
	assign fill_word = fill_src ? fill_data : wdata;

	// Compare reads from the hit way, otherwise from the enabled way
	assign sel1 = comp ? (hit[1] & valid[1]) : way_en[1];
	assign rdata = sel1 ? data_arr[1][idx][offset] : data_arr[0][idx][offset];
	assign stored_tag = sel1 ? tag_arr[1][idx] : tag_arr[0][idx];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (fill_we[w]) begin
					valid_q[w][idx] <= 1'b1;
					dirty_q[w][idx] <= 1'b0;   // Fresh line from memory
				end else if (cmp_we[w]) begin
					dirty_q[w][idx] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (fill_we[w]) begin
				tag_arr[w][idx] <= tag;
				data_arr[w][idx][offset] <= fill_word;
			end else if (cmp_we[w]) begin
				data_arr[w][idx][offset] <= wdata;
			end
		end
	end

endmodule

// File: rtl/mem_req_buffer.sv
`timescale 1ns/1ps

module mem_req_buffer #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  mem_pkg::mem_req_t push_data,
	input  logic pop,
	output logic full,
	output logic req_valid,
	output mem_pkg::mem_req_t head
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	mem_pkg::mem_req_t entries [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;   // Wrap for any depth
	endfunction

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign req_valid = (count != '0);
	assign head = entries[rd_ptr];
	assign do_push = push & ~full;
	assign do_pop = pop & req_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_data;
		end
	end

endmodule

// File: rtl/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
	parameter int MEM_LAT = 3,
	parameter int ADDR_W = $bits(mem_pkg::addr_t)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid,
	input  mem_pkg::mem_req_t head,
	output logic pop,
	output mem_pkg::mem_rsp_t mem_rsp
);

	localparam int WORDS = 2 ** (ADDR_W - 1);   // Word addressed

	mem_pkg::word_t mem [WORDS];
	mem_pkg::word_t data_pipe [MEM_LAT];
	logic [MEM_LAT-1:0] vld_pipe;
	logic [ADDR_W-2:0] word_addr;
	logic rd_pop;

	assign pop = req_valid;   // Never stalls
	assign word_addr = head.addr[ADDR_W-2:0];
	assign rd_pop = req_valid & ~head.wr;

	initial begin
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (req_valid && head.wr) begin
			mem[word_addr] <= head.data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= (vld_pipe << 1) | MEM_LAT'(rd_pop);
		end
	end

	// Data shifts alongside the valid bits
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[word_addr];
		for (int i = 1; i < MEM_LAT; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign mem_rsp.rvalid = vld_pipe[MEM_LAT-1];
	assign mem_rsp.rdata = data_pipe[MEM_LAT-1];

endmodule

// File: rtl/cache_controller.sv
`timescale 1ns/1ps

module cache_controller #(
	parameter int IDX_W = 5
) (
	input  logic clk,
	input  logic rst_n,
	input  mem_pkg::cpu_req_t cpu_req,
	input  mem_pkg::way_sel_t way_valid,
	input  mem_pkg::way_sel_t way_dirty,
	input  mem_pkg::way_sel_t way_hit,
	input  mem_pkg::word_t way_rdata,
	input  mem_pkg::tag_t way_tag,
	input  logic buf_full,
	input  mem_pkg::mem_rsp_t mem_rsp,
	output mem_pkg::cpu_rsp_t cpu_rsp,
	output mem_pkg::way_sel_t way_en,
	output logic comp,
	output logic write,
	output logic fill_src,
	output logic [IDX_W-1:0] idx,
	output logic [mem_pkg::WOFF_W-1:0] offset,
	output mem_pkg::tag_t tag,
	output mem_pkg::word_t way_wdata,
	output logic push,
	output mem_pkg::mem_req_t mem_req
);

	localparam int LINE_W = $bits(mem_pkg::addr_t) - mem_pkg::OFFSET_W;  // Line number bits
	localparam int TAG_W = LINE_W - IDX_W;

	mem_pkg::ctrl_state_t state;
	mem_pkg::cpu_req_t req_q;
	mem_pkg::word_t rdata_q;
	mem_pkg::way_sel_t alloc_way_q;
	mem_pkg::way_sel_t alloc_sel;
	logic [mem_pkg::WOFF_W-1:0] req_cnt;   // Words pushed to the buffer
	logic [mem_pkg::WOFF_W-1:0] rsp_cnt;   // Fill words received
	logic stall_q;
	logic done_q;
	logic hit_q;
	logic err_q;
	logic victim_q;
	logic any_hit;
	logic alloc_dirty;
	logic [IDX_W-1:0] req_idx;
	logic [mem_pkg::WOFF_W-1:0] req_off;
	logic [LINE_W-1:0] req_line;
	logic [LINE_W-1:0] wb_line;

	assign req_idx = req_q.addr[mem_pkg::OFFSET_W +: IDX_W];
	assign req_off = req_q.addr[1 +: mem_pkg::WOFF_W];   // Bit 0 ignored
	assign req_line = req_q.addr[mem_pkg::OFFSET_W +: LINE_W];
	assign wb_line = {way_tag[TAG_W-1:0], req_idx};      // Line of the evicted data

	assign any_hit = |(way_valid & way_hit);

	// Invalid way first, otherwise the victim bit decides
	assign alloc_sel = !way_valid[0] ? 2'b01 :
		!way_valid[1] ? 2'b10 :
		victim_q ? 2'b10 : 2'b01;
	assign alloc_dirty = |(alloc_sel & way_valid & way_dirty);

	assign idx = req_idx;
	assign tag = mem_pkg::tag_t'(req_line >> IDX_W);
	assign way_wdata = req_q.wdata;

	assign cpu_rsp = '{
		done: done_q,
		stall: stall_q,
		hit: hit_q,
		err: err_q,
		rdata: rdata_q
	};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_pkg::IDLE;
			stall_q <= 1'b0;
			done_q <= 1'b0;
			hit_q <= 1'b0;
			err_q <= 1'b0;
			victim_q <= 1'b0;
			alloc_way_q <= '0;
			req_cnt <= '0;
			rsp_cnt <= '0;
		end else begin
			done_q <= 1'b0;   // Pulses by default
			err_q <= 1'b0;
			case (state)
				mem_pkg::IDLE: begin
					if (cpu_req.rd || cpu_req.wr) begin
						stall_q <= 1'b1;
						hit_q <= 1'b0;
						state <= mem_pkg::COMPARE;
					end
				end
				mem_pkg::COMPARE: begin
					victim_q <= ~victim_q;   // Toggles on every compare
					if (any_hit) begin
						done_q <= 1'b1;
						hit_q <= 1'b1;
						stall_q <= 1'b0;
						state <= mem_pkg::IDLE;
					end else begin
						state <= mem_pkg::ALLOC;
					end
				end
				mem_pkg::ALLOC: begin
					alloc_way_q <= alloc_sel;
					req_cnt <= '0;
					rsp_cnt <= '0;
					state <= alloc_dirty ? mem_pkg::WB_READ : mem_pkg::FILL_REQ;
				end
				mem_pkg::WB_READ: begin
					if (!buf_full) begin
						req_cnt <= req_cnt + 1'b1;   // Wraps to zero for the fill
						if (&req_cnt) begin
							state <= mem_pkg::FILL_REQ;
						end
					end
				end
				mem_pkg::FILL_REQ: begin
					if (!buf_full) begin
						req_cnt <= req_cnt + 1'b1;
						if (&req_cnt) begin
							state <= mem_pkg::FILL_WAIT;
						end
					end
					// Short latency can return data before all reads are queued
					if (mem_rsp.rvalid) begin
						rsp_cnt <= rsp_cnt + 1'b1;
					end
				end
				mem_pkg::FILL_WAIT: begin
					if (mem_rsp.rvalid) begin
						rsp_cnt <= rsp_cnt + 1'b1;
						if (&rsp_cnt) begin
							state <= mem_pkg::FINISH;
						end
					end
				end
				mem_pkg::FINISH: begin
					done_q <= 1'b1;
					hit_q <= 1'b0;
					stall_q <= 1'b0;
					state <= mem_pkg::IDLE;
				end
				default: begin
					err_q <= 1'b1;   // Corrupted state
					stall_q <= 1'b0;
					state <= mem_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mem_pkg::IDLE && (cpu_req.rd || cpu_req.wr)) begin
			req_q <= cpu_req;
		end
		if ((state == mem_pkg::COMPARE && any_hit) || state == mem_pkg::FINISH) begin
			rdata_q <= way_rdata;
		end
	end

	always_comb begin
		way_en = '0;
		comp = 1'b0;
		write = 1'b0;
		fill_src = 1'b0;
		offset = req_off;
		push = 1'b0;
		mem_req = '0;
		case (state)
			mem_pkg::COMPARE, mem_pkg::FINISH: begin
				way_en = 2'b11;
				comp = 1'b1;
				write = req_q.wr;   // Only lands in a hit way
			end
			mem_pkg::WB_READ: begin
				way_en = alloc_way_q;
				offset = req_cnt;
				push = !buf_full;
				mem_req.wr = 1'b1;
				mem_req.addr = mem_pkg::addr_t'({wb_line, req_cnt});
				mem_req.data = way_rdata;
			end
			mem_pkg::FILL_REQ: begin
				way_en = alloc_way_q;
				write = mem_rsp.rvalid;
				fill_src = 1'b1;
				offset = rsp_cnt;
				push = !buf_full;
				mem_req.addr = mem_pkg::addr_t'({req_line, req_cnt});
			end
			mem_pkg::FILL_WAIT: begin
				way_en = alloc_way_q;
				write = mem_rsp.rvalid;
				fill_src = 1'b1;
				offset = rsp_cnt;
			end
			default: begin
				way_en = '0;
			end
		endcase
	end

endmodule

// File: rtl/mem_system.sv
`timescale 1ns/1ps

module mem_system #(
	parameter int IDX_W = 5,
	parameter int FIFO_DEPTH = 4,
	parameter int MEM_LAT = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  mem_pkg::cpu_req_t cpu_req,
	output mem_pkg::cpu_rsp_t cpu_rsp
);

	mem_pkg::way_sel_t way_en;
	mem_pkg::way_sel_t way_valid;
	mem_pkg::way_sel_t way_dirty;
	mem_pkg::way_sel_t way_hit;
	mem_pkg::word_t way_rdata;
	mem_pkg::word_t way_wdata;
	mem_pkg::tag_t way_tag;
	mem_pkg::tag_t tag;
	mem_pkg::mem_req_t mem_req;
	mem_pkg::mem_req_t head;
	mem_pkg::mem_rsp_t mem_rsp;
	logic [IDX_W-1:0] idx;
	logic [mem_pkg::WOFF_W-1:0] offset;
	logic comp;
	logic write;
	logic fill_src;
	logic push;
	logic buf_full;
	logic req_valid;
	logic pop;

	cache_controller #(.IDX_W(IDX_W)) ctrl_i (
		.clk(clk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_rsp(cpu_rsp),
		.way_valid(way_valid), .way_dirty(way_dirty), .way_hit(way_hit),
		.way_rdata(way_rdata), .way_tag(way_tag),
		.buf_full(buf_full), .mem_rsp(mem_rsp),
		.way_en(way_en), .comp(comp), .write(write), .fill_src(fill_src),
		.idx(idx), .offset(offset), .tag(tag), .way_wdata(way_wdata),
		.push(push), .mem_req(mem_req)
	);

	cache_ways #(.IDX_W(IDX_W)) ways_i (
		.clk(clk), .rst_n(rst_n),
		.way_en(way_en), .comp(comp), .write(write), .fill_src(fill_src),
		.idx(idx), .offset(offset), .tag(tag),
		.wdata(way_wdata), .fill_data(mem_rsp.rdata),   // Fill words straight from memory
		.valid(way_valid), .dirty(way_dirty), .hit(way_hit),
		.rdata(way_rdata), .stored_tag(way_tag)
	);

	mem_req_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) buf_i (
		.clk(clk), .rst_n(rst_n),
		.push(push), .push_data(mem_req), .pop(pop),
		.full(buf_full), .req_valid(req_valid), .head(head)
	);

	main_memory #(.MEM_LAT(MEM_LAT), .ADDR_W($bits(mem_pkg::addr_t))) mem_i (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .head(head),
		.pop(pop), .mem_rsp(mem_rsp)
	);

endmodule

// File: tests/mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb;

	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 200;   // Watchdog budget per test line

	logic clk = 1'b0;
	logic rst_n;
	mem_pkg::cpu_req_t cpu_req;
	mem_pkg::cpu_rsp_t cpu_rsp;

	logic [1:0] op_arr [MAX_TESTS];   // 0 read, 1 write, 2 write strobed during stall
	mem_pkg::addr_t addr_arr [MAX_TESTS];
	mem_pkg::word_t wdata_arr [MAX_TESTS];
	mem_pkg::word_t exp_rdata_arr [MAX_TESTS];
	logic exp_hit_arr [MAX_TESTS];
	int num_tests = 0;
	int access_cnt = 0;
	int mismatch_cnt = 0;
	int other_cnt = 0;
	int done_cnt = 0;
	logic tests_loaded = 1'b0;
	logic err_seen = 1'b0;
	mem_pkg::cpu_rsp_t last_rsp;
	time done_time;

	mem_system #(.IDX_W(5), .FIFO_DEPTH(4), .MEM_LAT(3)) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp)
	);

	always #20 clk = ~clk;

	// Responses are sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && cpu_rsp.done) begin
			last_rsp = cpu_rsp;
			done_time = $time;
			done_cnt = done_cnt + 1;
		end
		if (rst_n && cpu_rsp.err && !err_seen) begin
			$display("error output went high at %0t", $time);
			other_cnt = other_cnt + 1;
			err_seen = 1'b1;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			mismatch_cnt = mismatch_cnt + 1;
		end
	endtask

	task automatic load_tests();
		int fd;
		int n;
		string line_buf;
		logic [15:0] f_op;
		logic [15:0] f_addr;
		logic [15:0] f_wdata;
		logic [15:0] f_rdata;
		logic [15:0] f_hit;
		fd = $fopen("tests/mem_system_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/mem_system_tests.txt");
			other_cnt = other_cnt + 1;
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				n = $sscanf(line_buf, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_rdata, f_hit);
				if (n == 5 && num_tests < MAX_TESTS) begin   // Comment lines do not scan
					op_arr[num_tests] = f_op[1:0];
					addr_arr[num_tests] = f_addr;
					wdata_arr[num_tests] = f_wdata;
					exp_rdata_arr[num_tests] = f_rdata;
					exp_hit_arr[num_tests] = f_hit[0];
					num_tests = num_tests + 1;
				end
			end
			$fclose(fd);
			tests_loaded = 1'b1;
		end
	endtask

	// Must land while a miss keeps the controller busy
	task automatic strobe_ignored(input int j);
		@(negedge clk);
		@(negedge clk);
		if (!cpu_rsp.stall) begin
			$display("cache was idle when the ignored request of entry %0d was due", j);
			other_cnt = other_cnt + 1;
		end else begin
			@(posedge clk);
			cpu_req <= '{rd: 1'b0, wr: 1'b1, addr: addr_arr[j], wdata: wdata_arr[j]};
			@(posedge clk);
			cpu_req.wr <= 1'b0;
		end
	endtask

	task automatic run_access(input int i);
		int target;
		int latency;
		time t_strobe;
		@(negedge clk);
		while (cpu_rsp.stall) begin
			@(negedge clk);
		end
		target = done_cnt + 1;
		@(posedge clk);
		t_strobe = $time;
		cpu_req <= '{rd: (op_arr[i] == 2'd0), wr: (op_arr[i] == 2'd1),
			addr: addr_arr[i], wdata: wdata_arr[i]};
		@(posedge clk);
		cpu_req.rd <= 1'b0;   // One-cycle strobe
		cpu_req.wr <= 1'b0;
		if (i + 1 < num_tests && op_arr[i+1] == 2'd2) begin
			strobe_ignored(i + 1);
		end
		wait (done_cnt >= target);
		latency = int'((done_time - t_strobe - 20) / 40);   // Edges from strobe to done
		if (op_arr[i] == 2'd0) begin
			compare_value($sformatf("rdata entry %0d", i), 32'(last_rsp.rdata),
				32'(exp_rdata_arr[i]));
		end
		compare_value($sformatf("hit entry %0d", i), 32'(last_rsp.hit), 32'(exp_hit_arr[i]));
		if (exp_hit_arr[i]) begin
			compare_value($sformatf("hit_latency entry %0d", i), 32'(latency), 32'd2);
		end
		access_cnt = access_cnt + 1;
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_req = '0;
		load_tests();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		if (tests_loaded) begin
			for (int i = 0; i < num_tests; i++) begin
				if (op_arr[i] != 2'd2) begin
					run_access(i);
				end
			end
			repeat (4) @(negedge clk);
			compare_value("done_count", 32'(done_cnt), 32'(access_cnt));   // Extra done means a stalled strobe got in
		end
		$display("errors: %0d mismatches, %0d other failures over %0d accesses",
			mismatch_cnt, other_cnt, access_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (tests_loaded);
		repeat (num_tests * CYCLES_PER_TEST) @(posedge clk);
		$display("timeout: no result after %0d cycles", num_tests * CYCLES_PER_TEST);
		$display("errors: %0d mismatches, %0d other failures over %0d accesses",
			mismatch_cnt, other_cnt, access_cnt);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tests/mem_system_tests.txt
# op (0 read, 1 write, 2 write strobed during the previous miss) addr wdata exp_rdata exp_hit
# all values hex, exp_rdata is checked on reads only
0 0108 0000 0000 0
0 0108 0000 0000 1
1 0108 a1b2 0000 1
0 0108 0000 a1b2 1
0 0208 0000 0000 0
0 0108 0000 a1b2 1
1 020a 5c3d 0000 1
0 020a 0000 5c3d 1
0 0108 0000 a1b2 1
0 0308 0000 0000 0
2 0208 dead 0000 0
0 020a 0000 5c3d 1
0 0208 0000 0000 1
0 0108 0000 a1b2 0
0 010a 0000 0000 1
0 020a 0000 5c3d 0
0 0308 0000 0000 1
1 010c 7e11 0000 0
0 0108 0000 a1b2 1
0 010a 0000 0000 1
0 010e 0000 0000 1
0 010c 0000 7e11 1
1 1230 0f0f 0000 0
0 1232 0000 0000 1
0 1230 0000 0f0f 1
0 0408 0000 0000 0
2 0408 beef 0000 0
0 010c 0000 7e11 0
0 0408 0000 0000 1
0 020a 0000 5c3d 0

// File: sim.f
rtl/mem_pkg.sv
rtl/cache_ways.sv
rtl/mem_req_buffer.sv
rtl/main_memory.sv
rtl/cache_controller.sv
rtl/mem_system.sv
tests/mem_system_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module mem_system_tb -f sim.f
out=$(./obj_dir/Vmem_system_tb)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q '^TEST RESULT: PASS$'; then
	exit 0
fi
exit 1
